// ==== sim.f ====
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/idu.sv
rtl/gpr_file.sv
rtl/alu.sv
rtl/exu.sv
rtl/rv_core.sv
verification/tb_mem.sv
verification/core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/core_tb.sv ====
module core_tb;

    timeunit 1ns;
    timeprecision 1ns;

    import core_pkg::*;
    import rv_isa_pkg::*;

    logic        clk;
    logic        arst_n;
    logic [31:0] inst;
    logic [31:0] inst_addr;
    logic        mem_w_en;
    logic [31:0] mem_w_addr;
    logic [31:0] mem_w_data;
    logic        halted;

    logic [31:0] rng;
    int          errors;
    int          pass_count;
    int          fail_count;
    int          wr_idx;

    // reference model state.
    logic [31:0] m_pc;
    logic [31:0] m_regs [0:31];
    logic        m_halted;
    int          m_stores;
    logic        exp_st;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    logic [31:0] m_word;

    rv_core dut_i
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst       (inst),
        .inst_addr  (inst_addr),
        .mem_w_en   (mem_w_en),
        .mem_w_addr (mem_w_addr),
        .mem_w_data (mem_w_data),
        .halted     (halted)
    );

    tb_mem mem_i
    (
        .clk       (clk),
        .inst_addr (inst_addr),
        .inst      (inst),
        .w_en      (mem_w_en),
        .w_addr    (mem_w_addr),
        .w_data    (mem_w_data)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] fetch(logic [31:0] addr);
        if (addr[31:10] != reset_pc[31:10])
            return '0;
        return mem_i.imem[addr[9:2]];
    endfunction

    task automatic step_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] nxt;
        logic [31:0] res;
        logic        wr;
        w   = fetch(m_pc);
        a   = m_regs[w[19:15]];
        b   = m_regs[w[24:20]];
        nxt = m_pc; // unknown words hold the pc.
        res = '0;
        wr  = 1'b0;
        case (w[6:0])
            op_auipc:
            begin
                res = m_pc + {w[31:12], 12'b0};
                nxt = m_pc + 4;
                wr  = 1'b1;
            end
            op_jal:
            begin
                res = m_pc + 4;
                nxt = m_pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                wr  = 1'b1;
            end
            op_jalr:
                if (w[14:12] == 3'b000)
                begin
                    res = m_pc + 4;
                    nxt = (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
                    wr  = 1'b1;
                end
            op_branch:
                if (w[14:12] == 3'b000)
                    nxt = (a == b) ? m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0}
                                   : m_pc + 4;
            op_store:
                if (w[14:12] == 3'b010)
                begin
                    m_stores++;
                    nxt = m_pc + 4;
                end
            op_opimm:
                if (w[14:12] == 3'b000)
                begin
                    res = a + {{20{w[31]}}, w[31:20]};
                    nxt = m_pc + 4;
                    wr  = 1'b1;
                end
            op_op:
                if (w[14:12] == 3'b000 && w[31:25] == 7'b0)
                begin
                    res = a + b;
                    nxt = m_pc + 4;
                    wr  = 1'b1;
                end
            op_system:
                if (w == 32'h0010_0073)
                begin
                    m_halted = 1'b1;
                    nxt      = m_pc + 4; // the halting edge still moves the pc.
                end
            default:
                nxt = m_pc;
        endcase
        if (wr && w[11:7] != 5'd0)
            m_regs[w[11:7]] = res;
        m_pc = nxt;
    endtask

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            m_pc     = reset_pc;
            m_halted = 1'b0;
            m_stores = 0;
            for (int k = 0; k < 32; k++)
                m_regs[k] = '0;
        end
        else if (!m_halted)
            step_model();
    end

    always_comb
    begin
        m_word   = fetch(m_pc);
        exp_st   = !m_halted && m_word[6:0] == op_store && m_word[14:12] == 3'b010;
        exp_addr = m_regs[m_word[19:15]] + {{20{m_word[31]}}, m_word[31:25], m_word[11:7]};
        exp_data = m_regs[m_word[24:20]];
    end

    task automatic value_error(string what, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    pc_check: assert property (@(negedge clk) inst_addr == m_pc)
        else value_error("inst_addr", inst_addr, m_pc);
    halt_check: assert property (@(negedge clk) halted == m_halted)
        else value_error("halted", {31'b0, halted}, {31'b0, m_halted});
    store_en_check: assert property (@(negedge clk) mem_w_en == exp_st)
        else value_error("mem_w_en", {31'b0, mem_w_en}, {31'b0, exp_st});
    store_addr_check: assert property (@(negedge clk) exp_st |-> mem_w_addr == exp_addr)
        else value_error("mem_w_addr", mem_w_addr, exp_addr);
    store_data_check: assert property (@(negedge clk) exp_st |-> mem_w_data == exp_data)
        else value_error("mem_w_data", mem_w_data, exp_data);

    task automatic emit(logic [31:0] word);
        mem_i.imem[wr_idx] = word;
        wr_idx++;
    endtask

    task automatic emit_nops(int n);
        for (int k = 0; k < n; k++)
            emit(mem_i.enc_i(op_opimm, 5'd0, 5'd0, 12'd0));
    endtask

    // holds the core in reset while a new program is assembled.
    task automatic begin_program();
        @(negedge clk);
        arst_n = 1'b0;
        mem_i.clear();
        wr_idx = 0;
    endtask

    task automatic release_reset();
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic wait_halt(int limit);
        int n;
        n = 0;
        while (!halted)
        begin
            @(negedge clk);
            n++;
            if (n > limit)
            begin
                $display("timeout: the core did not halt within %0d cycles", limit);
                $display("RESULT: FAIL");
                $finish;
            end
        end
    endtask

    task automatic wait_cycles(int n);
        for (int k = 0; k < n; k++)
            @(negedge clk);
    endtask

    task automatic finish_test(string name, int errors_before);
        store_count_check: assert (mem_i.store_addr.size() == m_stores)
            else
            begin
                errors++;
                $display("the memory saw %0d stores but the model made %0d",
                         mem_i.store_addr.size(), m_stores);
            end
        if (errors == errors_before)
        begin
            pass_count++;
            $display("test %s: pass", name);
        end
        else
        begin
            fail_count++;
            $display("test %s: fail", name);
        end
    endtask

    initial
    begin
        int e;
        int off;
        logic [11:0] v;
        clk    = 1'b0;
        arst_n = 1'b0;
        rng    = 32'hed85_1b49;
        errors = 0;
        pass_count = 0;
        fail_count = 0;
        mem_i.clear();

        e = errors;
        begin_program();
        emit_nops(2);
        emit(32'h0010_0073);
        release_reset();
        wait_halt(20);
        finish_test("reset", e);

        e = errors;
        begin_program();
        for (int k = 0; k < 16; k++)
        begin
            if (next_rand() & 1)
                emit(mem_i.enc_i(op_opimm, 5'(next_rand() % 8), 5'(next_rand() % 8),
                                 12'(next_rand())));
            else
                emit(mem_i.enc_add(5'(next_rand() % 8), 5'(next_rand() % 8),
                                   5'(next_rand() % 8)));
        end
        for (int k = 0; k < 8; k++)
            emit(mem_i.enc_sw(5'd0, k[4:0], 12'(4 * k)));
        emit(32'h0010_0073);
        release_reset();
        wait_halt(100);
        finish_test("arith_store", e);

        e = errors;
        begin_program();
        v = 12'(next_rand());
        emit(mem_i.enc_i(op_opimm, 5'd1, 5'd0, v));
        emit(mem_i.enc_i(op_opimm, 5'd2, 5'd0, v));
        emit(mem_i.enc_i(op_opimm, 5'd3, 5'd0, v ^ 12'd1));
        for (int k = 0; k < 4; k++)
        begin
            off = 4 * (2 + next_rand() % 3);
            emit(mem_i.enc_beq(5'd1, 5'd2, 13'(off)));
            emit_nops(off / 4 - 1);
            off = 4 * (2 + next_rand() % 3);
            emit(mem_i.enc_beq(5'd1, 5'd3, 13'(off)));
            emit_nops(off / 4 - 1);
        end
        emit(32'h0010_0073);
        release_reset();
        wait_halt(100);
        finish_test("branch", e);

        e = errors;
        begin_program();
        emit(mem_i.enc_auipc(5'd7, 20'(next_rand())));
        emit(mem_i.enc_sw(5'd0, 5'd7, 12'd0));
        emit(mem_i.enc_auipc(5'd5, 20'd0));
        emit(mem_i.enc_i(op_jalr, 5'd6, 5'd5, 12'd13)); // the odd target lands on the sw below.
        emit(32'h0);
        emit(mem_i.enc_sw(5'd0, 5'd6, 12'd4));
        emit(mem_i.enc_jal(5'd8, 21'd8));
        emit(32'h0);
        emit(mem_i.enc_sw(5'd0, 5'd8, 12'd8));
        emit(32'h0010_0073);
        release_reset();
        wait_halt(50);
        finish_test("jump_auipc", e);

        e = errors;
        begin_program();
        emit(mem_i.enc_i(op_opimm, 5'd4, 5'd0, 12'h123));
        emit(32'h0010_0073);
        for (int k = 0; k < 4; k++)
            emit(mem_i.enc_sw(5'd0, 5'd4, 12'(4 * k)));
        release_reset();
        wait_halt(20);
        wait_cycles(20);
        finish_test("halt", e);

        e = errors;
        begin_program();
        emit(mem_i.enc_i(op_opimm, 5'd9, 5'd0, 12'h055));
        emit(32'h0);
        emit(mem_i.enc_sw(5'd0, 5'd9, 12'd0));
        release_reset();
        wait_cycles(12);
        finish_test("unknown", e);

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== verification/tb_mem.sv ====
module tb_mem
(
    input  logic        clk,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst,
    input  logic        w_en,
    input  logic [31:0] w_addr,
    input  logic [31:0] w_data
);

    timeunit 1ns;
    timeprecision 1ns;

    import rv_isa_pkg::*;

    logic [31:0] imem [0:255];
    logic [31:0] store_addr [$];

    // the program window is 1 KiB at the reset pc and anything outside reads as zero.
    assign inst = (inst_addr[31:10] == core_pkg::reset_pc[31:10]) ? imem[inst_addr[9:2]] : '0;

    always @(posedge clk)
    begin
        if (w_en)
        begin
            store_addr.push_back(w_addr);
        end
    end

    task automatic clear();
        for (int k = 0; k < 256; k++)
            imem[k] = '0;
        store_addr.delete();
    endtask

    function automatic logic [31:0] enc_add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        inst_word_u w;
        w.r_view = '{funct7: f7_add, rs2: rs2, rs1: rs1, funct3: f3_add, rd: rd, opcode: op_op};
        return w;
    endfunction

    function automatic logic [31:0] enc_i(logic [6:0] op, logic [4:0] rd, logic [4:0] rs1,
                                          logic [11:0] imm);
        inst_word_u w;
        w.i_view = '{imm_11_0: imm, rs1: rs1, funct3: 3'b000, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic logic [31:0] enc_sw(logic [4:0] rs1, logic [4:0] rs2, logic [11:0] imm);
        inst_word_u w;
        w.s_view = '{imm_11_5: imm[11:5], rs2: rs2, rs1: rs1, funct3: f3_sw,
                     imm_4_0: imm[4:0], opcode: op_store};
        return w;
    endfunction

    function automatic logic [31:0] enc_beq(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
        inst_word_u w;
        w.b_view = '{imm_12: imm[12], imm_10_5: imm[10:5], rs2: rs2, rs1: rs1, funct3: f3_beq,
                     imm_4_1: imm[4:1], imm_11: imm[11], opcode: op_branch};
        return w;
    endfunction

    function automatic logic [31:0] enc_auipc(logic [4:0] rd, logic [19:0] imm);
        inst_word_u w;
        w.u_view = '{imm_31_12: imm, rd: rd, opcode: op_auipc};
        return w;
    endfunction

    function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] imm);
        inst_word_u w;
        w.j_view = '{imm_20: imm[20], imm_10_1: imm[10:1], imm_11: imm[11],
                     imm_19_12: imm[19:12], rd: rd, opcode: op_jal};
        return w;
    endfunction

endmodule

// ==== rtl/rv_core.sv ====
module rv_core
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [31:0]               inst,
    output logic [core_pkg::xlen-1:0] inst_addr,
    output logic                      mem_w_en,
    output logic [core_pkg::xlen-1:0] mem_w_addr,
    output logic [core_pkg::xlen-1:0] mem_w_data,
    output logic                      halted
);

    import core_pkg::*;
    import rv_isa_pkg::*;

    localparam int idx_w = $clog2(gpr_count);

    logic [xlen-1:0]  pc;
    logic [xlen-1:0]  pc_next;
    logic             pc_w_en;
    inst_num_t        inst_num;
    inst_type_t       inst_type;
    logic [idx_w-1:0] rs1;
    logic [idx_w-1:0] rs2;
    logic [idx_w-1:0] rd;
    logic [xlen-1:0]  imm;
    logic [xlen-1:0]  src1;
    logic [xlen-1:0]  src2;
    logic [xlen-1:0]  alu_a;
    logic [xlen-1:0]  alu_b;
    alu_func_t        alu_func;
    logic [xlen-1:0]  alu_result;
    logic             alu_eq;
    logic [xlen-1:0]  srd;
    logic             gpr_w_en;
    logic             exu_mem_w_en;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            pc <= reset_pc;
        else if (pc_w_en && !halted)
            pc <= pc_next;
    end

    // once set, only reset brings the core back.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            halted <= 1'b0;
        else if (inst_num == ebreak)
            halted <= 1'b1;
    end

    assign inst_addr = pc;
    assign mem_w_en  = exu_mem_w_en & ~halted;

    idu idu_i
    (
        .inst      (inst),
        .inst_num  (inst_num),
        .inst_type (inst_type),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm)
    );

    gpr_file gpr_file_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .w_en   (gpr_w_en & ~halted),
        .w_data (srd),
        .src1   (src1),
        .src2   (src2)
    );

    alu alu_i
    (
        .a      (alu_a),
        .b      (alu_b),
        .func   (alu_func),
        .result (alu_result),
        .eq     (alu_eq)
    );

    exu exu_i
    (
        .inst_num   (inst_num),
        .inst_type  (inst_type),
        .imm        (imm),
        .pc         (pc),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result),
        .alu_eq     (alu_eq),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_func   (alu_func),
        .pc_next    (pc_next),
        .pc_w_en    (pc_w_en),
        .srd        (srd),
        .gpr_w_en   (gpr_w_en),
        .mem_w_en   (exu_mem_w_en),
        .mem_w_addr (mem_w_addr),
        .mem_w_data (mem_w_data)
    );

endmodule

// ==== rtl/exu.sv ====
module exu
(
    input  rv_isa_pkg::inst_num_t     inst_num,
    input  rv_isa_pkg::inst_type_t    inst_type,
    input  logic [core_pkg::xlen-1:0] imm,
    input  logic [core_pkg::xlen-1:0] pc,
    input  logic [core_pkg::xlen-1:0] src1,
    input  logic [core_pkg::xlen-1:0] src2,
    input  logic [core_pkg::xlen-1:0] alu_result,
    input  logic                      alu_eq,
    output logic [core_pkg::xlen-1:0] alu_a,
    output logic [core_pkg::xlen-1:0] alu_b,
    output core_pkg::alu_func_t       alu_func,
    output logic [core_pkg::xlen-1:0] pc_next,
    output logic                      pc_w_en,
    output logic [core_pkg::xlen-1:0] srd,
    output logic                      gpr_w_en,
    output logic                      mem_w_en,
    output logic [core_pkg::xlen-1:0] mem_w_addr,
    output logic [core_pkg::xlen-1:0] mem_w_data
);

    import core_pkg::*;
    import rv_isa_pkg::*;

    logic [xlen-1:0] pc_base;
    logic [xlen-1:0] pc_offset;
    logic [xlen-1:0] pc_sum;

    // the next pc has its own adder so the alu stays free for the link value.
    always_comb
    begin
        pc_base = (inst_num == jalr) ? src1 : pc;
        case (inst_num)
            jal, jalr: pc_offset = imm;
            beq:       pc_offset = alu_eq ? imm : inst_bytes;
            default:   pc_offset = inst_bytes;
        endcase
    end

    assign pc_sum  = pc_base + pc_offset;
    assign pc_next = (inst_num == jalr) ? {pc_sum[xlen-1:1], 1'b0} : pc_sum;

    always_comb
    begin
        case (inst_num)
            auipc:
            begin
                alu_a    = pc;
                alu_b    = imm;
                alu_func = add_s;
            end
            jal, jalr:
            begin
                alu_a    = pc; // link address.
                alu_b    = inst_bytes;
                alu_func = add_s;
            end
            beq:
            begin
                alu_a    = src1;
                alu_b    = src2;
                alu_func = xor_f;
            end
            sw, addi:
            begin
                alu_a    = src1;
                alu_b    = imm;
                alu_func = add_s;
            end
            add:
            begin
                alu_a    = src1;
                alu_b    = src2;
                alu_func = add_s;
            end
            default:
            begin
                alu_a    = '0;
                alu_b    = '0;
                alu_func = no_func;
            end
        endcase
    end

    assign pc_w_en  = (inst_type != fmt_none); // an unknown word stalls the pc.
    assign gpr_w_en = (inst_type inside {r, i, u, j});
    assign srd      = gpr_w_en ? alu_result : '0;

    assign mem_w_en   = (inst_type == s);
    assign mem_w_addr = alu_result;
    assign mem_w_data = src2;

endmodule

// ==== rtl/alu.sv ====
module alu
(
    input  logic [core_pkg::xlen-1:0] a,
    input  logic [core_pkg::xlen-1:0] b,
    input  core_pkg::alu_func_t       func,
    output logic [core_pkg::xlen-1:0] result,
    output logic                      eq
);

    import core_pkg::*;

    always_comb
    begin
        case (func)
            add_s:   result = a + b;
            xor_f:   result = a ^ b;
            default: result = '0;
        endcase
    end

    // with xor_f a zero result means both operands are equal.
    assign eq = (result == '0);

endmodule

// ==== rtl/gpr_file.sv ====
module gpr_file
(
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic [$clog2(core_pkg::gpr_count)-1:0] rs1,
    input  logic [$clog2(core_pkg::gpr_count)-1:0] rs2,
    input  logic [$clog2(core_pkg::gpr_count)-1:0] rd,
    input  logic                                   w_en,
    input  logic [core_pkg::xlen-1:0]              w_data,
    output logic [core_pkg::xlen-1:0]              src1,
    output logic [core_pkg::xlen-1:0]              src2
);

    import core_pkg::*;

    // x0 has no storage.
    logic [xlen-1:0] regs [1:gpr_count-1];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int k = 1; k < gpr_count; k++)
                regs[k] <= '0;
        end
        else if (w_en && rd != '0)
        begin
            regs[rd] <= w_data;
        end
    end

    assign src1 = (rs1 == '0) ? '0 : regs[rs1]; // x0 always reads as zero.
    assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rtl/idu.sv ====
module idu
(
    input  logic [31:0]                            inst,
    output rv_isa_pkg::inst_num_t                  inst_num,
    output rv_isa_pkg::inst_type_t                 inst_type,
    output logic [$clog2(core_pkg::gpr_count)-1:0] rs1,
    output logic [$clog2(core_pkg::gpr_count)-1:0] rs2,
    output logic [$clog2(core_pkg::gpr_count)-1:0] rd,
    output logic [core_pkg::xlen-1:0]              imm
);

    import rv_isa_pkg::*;
    import core_pkg::*;

    inst_word_u w;

    assign w = inst;

    // register fields sit at the same place in every format.
    assign rs1 = w.r_view.rs1;
    assign rs2 = w.r_view.rs2;
    assign rd  = w.r_view.rd;

    always_comb
    begin
        inst_num  = inst_none;
        inst_type = fmt_none;
        case (w.r_view.opcode)
            op_auipc:
            begin
                inst_num  = auipc;
                inst_type = u;
            end
            op_jal:
            begin
                inst_num  = jal;
                inst_type = j;
            end
            op_jalr:
            begin
                if (w.i_view.funct3 == f3_jalr)
                begin
                    inst_num  = jalr;
                    inst_type = i;
                end
            end
            op_branch:
            begin
                if (w.b_view.funct3 == f3_beq)
                begin
                    inst_num  = beq;
                    inst_type = b;
                end
            end
            op_store:
            begin
                if (w.s_view.funct3 == f3_sw)
                begin
                    inst_num  = sw;
                    inst_type = s;
                end
            end
            op_opimm:
            begin
                if (w.i_view.funct3 == f3_addi)
                begin
                    inst_num  = addi;
                    inst_type = i;
                end
            end
            op_op:
            begin
                if (w.r_view.funct3 == f3_add && w.r_view.funct7 == f7_add)
                begin
                    inst_num  = add;
                    inst_type = r;
                end
            end
            op_system:
            begin
                if (w.i_view.funct3 == 3'b000 && w.i_view.imm_11_0 == f12_ebreak &&
                    w.i_view.rs1 == '0 && w.i_view.rd == '0)
                begin
                    inst_num  = ebreak;
                    inst_type = i;
                end
            end
            default:
            begin
                inst_num  = inst_none;
                inst_type = fmt_none;
            end
        endcase
    end

    always_comb
    begin
        case (inst_type)
            i:       imm = {{(xlen-12){w.i_view.imm_11_0[11]}}, w.i_view.imm_11_0};
            s:       imm = {{(xlen-12){w.s_view.imm_11_5[6]}}, w.s_view.imm_11_5,
                            w.s_view.imm_4_0};
            b:       imm = {{(xlen-12){w.b_view.imm_12}}, w.b_view.imm_11,
                            w.b_view.imm_10_5, w.b_view.imm_4_1, 1'b0};
            u:       imm = {w.u_view.imm_31_12, 12'b0};
            j:       imm = {{(xlen-20){w.j_view.imm_20}}, w.j_view.imm_19_12,
                            w.j_view.imm_11, w.j_view.imm_10_1, 1'b0};
            default: imm = '0; // r format and unknown words carry no immediate.
        endcase
    end

endmodule

// ==== rtl/core_pkg.sv ====
package core_pkg;

    localparam int xlen = 32;

    // x0 is included in the count.
    localparam int gpr_count = 32;

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // size of one instruction, the default pc step and the link offset.
    localparam logic [xlen-1:0] inst_bytes = 32'd4;

    typedef enum logic [1:0] {no_func, add_s, xor_f} alu_func_t;

endpackage

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // major opcodes of the supported RV32I subset.
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_opimm  = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_jalr = 3'b000;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_sw   = 3'b010;
    localparam logic [2:0] f3_addi = 3'b000;
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [6:0] f7_add  = 7'b0000000;
    localparam logic [11:0] f12_ebreak = 12'h001; // imm field of the system opcode.

    typedef enum logic [3:0] {inst_none, auipc, jal, jalr, beq, sw, addi, add, ebreak} inst_num_t;

    typedef enum logic [2:0] {fmt_none, r, i, s, b, u, j} inst_type_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offsets are scrambled so the sign bit stays at bit 31.
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
        s_fmt_t s_view;
        b_fmt_t b_view;
        u_fmt_t u_view;
        j_fmt_t j_view;
    } inst_word_u;

endpackage
